//--- project.f
common/ingress_pkg.sv
hw/ingress_sat_counter.sv
hw/ingress_width_adapt.sv
ingress_buffer/ingress_port_buffer.sv
ingress_buffer/ingress_scheduler.sv
hw/p4_router_ingress.sv
verification/ingress_clk_gen.sv
verification/tb_p4_router_ingress.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_p4_router_ingress
FILELIST   := project.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only -Wall --timing --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/tb_p4_router_ingress.sv
////////////////////////////////////////////////////////////////////////////
// Directed tests for the P4 router ingress aggregator with a packet model
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_p4_router_ingress;

    localparam int NUM_PORTS = 4;
    localparam int MTU_BYTES = 64;
    localparam int CW        = 32;
    // Tests 2 to 4 each take at most about 1500 cycles with 12 packets of up to 32 beats
    // and gaps of up to 64 cycles, so a limit of 20000 cycles leaves a wide margin
    localparam int MAX_CYCLES = 20000;

    logic                        ing_16b_phys_ports;
    logic                        rst;
    logic [NUM_PORTS-1:0]        in_valid;
    logic [NUM_PORTS*16-1:0]     in_data;
    logic [NUM_PORTS*2-1:0]      in_keep;
    logic [NUM_PORTS-1:0]        in_last;
    logic [NUM_PORTS-1:0]        port_enable;
    logic [NUM_PORTS-1:0]        cnt_clear;
    logic                        out_valid;
    logic [63:0]                 out_data;
    logic [7:0]                  out_keep;
    logic                        out_last;
    logic [1:0]                  out_user;
    logic                        out_ready = 1'b1;
    logic                        bus_pkt_cnt_clear;
    logic [NUM_PORTS*CW-1:0]     port_pkt_cnt;
    logic [NUM_PORTS*CW-1:0]     port_drop_cnt;
    logic [CW-1:0]               bus_pkt_cnt;
    logic [NUM_PORTS-1:0]        buf_overflow;

    int seed = 58510;
    int errors = 0;
    int cycle_cnt = 0;
    // Mode 0 holds out_ready high while 1 randomizes it and 2 holds it low
    int ready_mode = 0;
    int exp_rx [NUM_PORTS];
    int exp_drop [NUM_PORTS];
    int exp_bus;
    // Port of the packet in progress on the bus and -1 between packets
    int cur_port = -1;

    // Expected words as {port, last, keep, data}
    logic [74:0] exp_q [$];

    ingress_clk_gen u_clk_gen (
        .ing_16b_phys_ports ( ing_16b_phys_ports ),
        .rst                ( rst                )
    );

    p4_router_ingress #(
        .NUM_PORTS ( NUM_PORTS ),
        .MTU_BYTES ( MTU_BYTES )
    ) u_dut (
        .ing_16b_phys_ports ( ing_16b_phys_ports ),
        .rst                ( rst                ),
        .in_valid           ( in_valid           ),
        .in_data            ( in_data            ),
        .in_keep            ( in_keep            ),
        .in_last            ( in_last            ),
        .port_enable        ( port_enable        ),
        .cnt_clear          ( cnt_clear          ),
        .out_valid          ( out_valid          ),
        .out_data           ( out_data           ),
        .out_keep           ( out_keep           ),
        .out_last           ( out_last           ),
        .out_user           ( out_user           ),
        .out_ready          ( out_ready          ),
        .bus_pkt_cnt_clear  ( bus_pkt_cnt_clear  ),
        .port_pkt_cnt       ( port_pkt_cnt       ),
        .port_drop_cnt      ( port_drop_cnt      ),
        .bus_pkt_cnt        ( bus_pkt_cnt        ),
        .buf_overflow       ( buf_overflow       )
    );

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    function automatic logic [63:0] keep_mask(input logic [7:0] keep);
        logic [63:0] m;
        for (int b = 0; b < 8; b++) begin
            m[8*b +: 8] = {8{keep[b]}};
        end
        return m;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and reference model

    // Byte i of a packet goes to byte lane i mod 8 of output word i / 8
    task automatic send_packet(input int port, input int len, input bit expect_out);
        logic [7:0]  pkt [$];
        logic [63:0] word;
        logic [7:0]  keep;
        logic [7:0]  hi;
        int          nbeats;
        int          nwords;
        nbeats = (len + 1) / 2;
        nwords = (len + 7) / 8;
        for (int i = 0; i < len; i++) begin
            pkt.push_back(8'($random(seed)));
        end
        if (expect_out) begin
            for (int w = 0; w < nwords; w++) begin
                word = '0;
                keep = '0;
                for (int b = 0; b < 8; b++) begin
                    if (8*w + b < len) begin
                        word[8*b +: 8] = pkt[8*w + b];
                        keep[b] = 1'b1;
                    end
                end
                exp_q.push_back({2'(port), (w == nwords - 1), keep, word});
            end
            exp_rx[port]++;
            exp_bus++;
        end
        for (int k = 0; k < nbeats; k++) begin
            hi = (2*k + 1 < len) ? pkt[2*k + 1] : 8'h00;
            @(posedge ing_16b_phys_ports);
            in_valid[port]         <= 1'b1;
            in_data[port*16 +: 16] <= {hi, pkt[2*k]};
            in_keep[port*2 +: 2]   <= (2*k + 1 < len) ? 2'b11 : 2'b01;
            in_last[port]          <= (k == nbeats - 1);
        end
        @(posedge ing_16b_phys_ports);
        in_valid[port] <= 1'b0;
        in_last[port]  <= 1'b0;
    endtask

    task automatic send_stream(input int port, input int count, input int gap,
                               input bit expect_out);
        int len;
        for (int n = 0; n < count; n++) begin
            len = 1 + int'($unsigned($random(seed)) % MTU_BYTES);
            send_packet(port, len, expect_out);
            repeat (gap) @(posedge ing_16b_phys_ports);
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge ing_16b_phys_ports);
        end
        repeat (8) @(posedge ing_16b_phys_ports);
    endtask

    task automatic check_counters();
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_value($sformatf("port_pkt_cnt[%0d]", p),
                        64'(port_pkt_cnt[p*CW +: CW]), 64'(exp_rx[p]));
            check_value($sformatf("port_drop_cnt[%0d]", p),
                        64'(port_drop_cnt[p*CW +: CW]), 64'(exp_drop[p]));
        end
        check_value("bus_pkt_cnt", 64'(bus_pkt_cnt), 64'(exp_bus));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Output monitor and ready driver

    // The oldest pending word of the port named by out_user must match
    task automatic check_output();
        int          idx;
        logic [74:0] ent;
        idx = -1;
        // A packet goes out whole so the port cannot change before its last word
        if (cur_port >= 0) begin
            check_value("out_user", 64'(out_user), 64'(cur_port));
        end
        cur_port = out_last ? -1 : int'(out_user);
        for (int i = 0; i < exp_q.size(); i++) begin
            if (idx < 0 && exp_q[i][74:73] == out_user) begin
                idx = i;
            end
        end
        if (idx < 0) begin
            errors++;
            $display("Output word on port %0d arrived with no packet pending", out_user);
        end else begin
            ent = exp_q[idx];
            check_value("out_data", out_data & keep_mask(out_keep),
                        ent[63:0] & keep_mask(ent[71:64]));
            check_value("out_keep", 64'(out_keep), 64'(ent[71:64]));
            check_value("out_last", 64'(out_last), 64'(ent[72]));
            exp_q.delete(idx);
        end
    endtask

    always @(posedge ing_16b_phys_ports) begin
        cycle_cnt <= cycle_cnt + 1;
        if (!rst && out_valid && out_ready) begin
            check_output();
        end
    end

    always @(posedge ing_16b_phys_ports) begin
        case (ready_mode)
            1:       out_ready <= 1'($random(seed));
            2:       out_ready <= 1'b0;
            default: out_ready <= 1'b1;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests

    task automatic test_single_packet();
        send_packet(2, 13, 1'b1);
        wait_drain();
        check_counters();
    endtask

    task automatic test_all_ports();
        fork
            send_stream(0, 3, 16, 1'b1);
            send_stream(1, 3, 16, 1'b1);
            send_stream(2, 3, 16, 1'b1);
            send_stream(3, 3, 16, 1'b1);
        join
        wait_drain();
        check_counters();
    endtask

    task automatic test_back_pressure();
        ready_mode = 1;
        fork
            send_stream(0, 2, 64, 1'b1);
            send_stream(1, 2, 64, 1'b1);
            send_stream(2, 2, 64, 1'b1);
            send_stream(3, 2, 64, 1'b1);
        join
        wait_drain();
        ready_mode = 0;
        check_counters();
    endtask

    // Port 1 starts from zero counts and must stay there while disabled
    task automatic test_disabled_port();
        @(posedge ing_16b_phys_ports);
        cnt_clear[1]   <= 1'b1;
        port_enable[1] <= 1'b0;
        @(posedge ing_16b_phys_ports);
        cnt_clear[1] <= 1'b0;
        exp_rx[1]   = 0;
        exp_drop[1] = 0;
        fork
            send_stream(0, 2, 16, 1'b1);
            send_stream(1, 2, 16, 1'b0);
            send_stream(2, 2, 16, 1'b1);
            send_stream(3, 2, 16, 1'b1);
        join
        wait_drain();
        repeat (64) @(posedge ing_16b_phys_ports);
        check_counters();
        @(posedge ing_16b_phys_ports);
        port_enable[1] <= 1'b1;
    endtask

    task automatic test_overflow();
        ready_mode = 2;
        repeat (2) @(posedge ing_16b_phys_ports);
        send_packet(0, 160, 1'b0);
        exp_drop[0]++;
        repeat (4) @(posedge ing_16b_phys_ports);
        check_value("buf_overflow[0]", 64'(buf_overflow[0]), 64'h1);
        check_value("out_valid", 64'(out_valid), 64'h0);
        check_counters();
        ready_mode = 0;
        send_packet(0, 10, 1'b1);
        wait_drain();
        check_counters();
    endtask

    // The port clears leave the bus count alone until its own clear
    task automatic test_clears();
        @(posedge ing_16b_phys_ports);
        cnt_clear <= '1;
        @(posedge ing_16b_phys_ports);
        cnt_clear <= '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            exp_rx[p]   = 0;
            exp_drop[p] = 0;
        end
        @(posedge ing_16b_phys_ports);
        check_value("buf_overflow", 64'(buf_overflow), 64'h0);
        check_counters();
        bus_pkt_cnt_clear <= 1'b1;
        @(posedge ing_16b_phys_ports);
        bus_pkt_cnt_clear <= 1'b0;
        exp_bus = 0;
        @(posedge ing_16b_phys_ports);
        check_counters();
        // Counting resumes after a clear
        send_packet(3, 24, 1'b1);
        wait_drain();
        check_counters();
    endtask

    initial begin
        in_valid          = '0;
        in_data           = '0;
        in_keep           = '0;
        in_last           = '0;
        port_enable       = '1;
        cnt_clear         = '0;
        bus_pkt_cnt_clear = 1'b0;
        exp_bus           = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            exp_rx[p]   = 0;
            exp_drop[p] = 0;
        end
        @(posedge ing_16b_phys_ports);
        while (rst) begin
            @(posedge ing_16b_phys_ports);
        end
        test_single_packet();
        test_all_ports();
        test_back_pressure();
        test_disabled_port();
        test_overflow();
        test_clears();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        wait (cycle_cnt >= MAX_CYCLES);
        $display("Timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
        $display("Errors: %0d", errors);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/ingress_clk_gen.sv
////////////////////////////////////////////////////////////////////////////
// Testbench clock of 8 ns and a synchronous reset held for 8 cycles
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ingress_clk_gen #(
    parameter int HALF_PERIOD_NS = 4,
    parameter int RESET_CYCLES   = 8
) (
    output logic ing_16b_phys_ports,
    output logic rst
);

    initial begin
        ing_16b_phys_ports = 1'b0;
        forever #(HALF_PERIOD_NS) ing_16b_phys_ports = ~ing_16b_phys_ports;
    end

    // Reset releases on a rising edge so the DUT sees it synchronously
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge ing_16b_phys_ports);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

//--- hw/p4_router_ingress.sv
////////////////////////////////////////////////////////////////////////////
// P4 router ingress, merges narrow 16-bit port streams onto one 64-bit bus
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module p4_router_ingress #(
    parameter int NUM_PORTS = 4,
    parameter int MTU_BYTES = 64,
    localparam int IN_B     = ingress_pkg::IN_DATA_BYTES,
    localparam int OUT_B    = ingress_pkg::OUT_DATA_BYTES,
    localparam int CW       = ingress_pkg::CNT_WIDTH,
    localparam int UW       = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
    input  var logic                        ing_16b_phys_ports,
    input  var logic                        rst,
    input  var logic [NUM_PORTS-1:0]        in_valid,
    input  var logic [NUM_PORTS*IN_B*8-1:0] in_data,
    input  var logic [NUM_PORTS*IN_B-1:0]   in_keep,
    input  var logic [NUM_PORTS-1:0]        in_last,
    input  var logic [NUM_PORTS-1:0]        port_enable,
    input  var logic [NUM_PORTS-1:0]        cnt_clear,
    output logic                            out_valid,
    output logic [OUT_B*8-1:0]              out_data,
    output logic [OUT_B-1:0]                out_keep,
    output logic                            out_last,
    output logic [UW-1:0]                   out_user,
    input  var logic                        out_ready,
    input  var logic                        bus_pkt_cnt_clear,
    output logic [NUM_PORTS*CW-1:0]         port_pkt_cnt,
    output logic [NUM_PORTS*CW-1:0]         port_drop_cnt,
    output logic [CW-1:0]                   bus_pkt_cnt,
    output logic [NUM_PORTS-1:0]            buf_overflow
);

    // Each port buffer holds at least two MTUs so one can fill while one drains
    localparam int BUF_DEPTH = ingress_pkg::buf_depth_for_mtu(MTU_BYTES);

    logic [NUM_PORTS-1:0]         wr_valid;
    logic [NUM_PORTS*OUT_B*8-1:0] wr_data;
    logic [NUM_PORTS*OUT_B-1:0]   wr_keep;
    logic [NUM_PORTS-1:0]         wr_last;
    logic [NUM_PORTS-1:0]         pkt_avail;
    logic [NUM_PORTS*OUT_B*8-1:0] rd_data;
    logic [NUM_PORTS*OUT_B-1:0]   rd_keep;
    logic [NUM_PORTS-1:0]         rd_last;
    logic [NUM_PORTS-1:0]         rd_pop;
    logic [NUM_PORTS-1:0]         pkt_commit;
    logic [NUM_PORTS-1:0]         pkt_drop;
    logic                         pkt_sent;

    ////////////////////////////////////////////////////////////////////////////
    // Per-port path

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        ingress_width_adapt u_adapt (
            .ing_16b_phys_ports ( ing_16b_phys_ports              ),
            .rst                ( rst                             ),
            .enable             ( port_enable[p]                  ),
            .in_valid           ( in_valid[p]                     ),
            .in_data            ( in_data[p*IN_B*8 +: IN_B*8]     ),
            .in_keep            ( in_keep[p*IN_B +: IN_B]         ),
            .in_last            ( in_last[p]                      ),
            .wr_valid           ( wr_valid[p]                     ),
            .wr_data            ( wr_data[p*OUT_B*8 +: OUT_B*8]   ),
            .wr_keep            ( wr_keep[p*OUT_B +: OUT_B]       ),
            .wr_last            ( wr_last[p]                      )
        );

        ingress_port_buffer #(
            .BUF_DEPTH ( BUF_DEPTH )
        ) u_buf (
            .ing_16b_phys_ports ( ing_16b_phys_ports              ),
            .rst                ( rst                             ),
            .cnt_clear          ( cnt_clear[p]                    ),
            .wr_valid           ( wr_valid[p]                     ),
            .wr_data            ( wr_data[p*OUT_B*8 +: OUT_B*8]   ),
            .wr_keep            ( wr_keep[p*OUT_B +: OUT_B]       ),
            .wr_last            ( wr_last[p]                      ),
            .rd_pop             ( rd_pop[p]                       ),
            .pkt_avail          ( pkt_avail[p]                    ),
            .rd_data            ( rd_data[p*OUT_B*8 +: OUT_B*8]   ),
            .rd_keep            ( rd_keep[p*OUT_B +: OUT_B]       ),
            .rd_last            ( rd_last[p]                      ),
            .pkt_commit         ( pkt_commit[p]                   ),
            .pkt_drop           ( pkt_drop[p]                     ),
            .overflow           ( buf_overflow[p]                 )
        );

        // Received counts only packets that were stored whole
        ingress_sat_counter #(
            .WIDTH ( CW )
        ) u_rx_cnt (
            .ing_16b_phys_ports ( ing_16b_phys_ports      ),
            .rst                ( rst                     ),
            .clear              ( cnt_clear[p]            ),
            .inc                ( pkt_commit[p]           ),
            .count              ( port_pkt_cnt[p*CW +: CW] )
        );

        ingress_sat_counter #(
            .WIDTH ( CW )
        ) u_drop_cnt (
            .ing_16b_phys_ports ( ing_16b_phys_ports       ),
            .rst                ( rst                      ),
            .clear              ( cnt_clear[p]             ),
            .inc                ( pkt_drop[p]              ),
            .count              ( port_drop_cnt[p*CW +: CW] )
        );
    end

    ////////////////////////////////////////////////////////////////////////////
    // Merge onto the wide bus

    ingress_scheduler #(
        .NUM_PORTS ( NUM_PORTS )
    ) u_sched (
        .ing_16b_phys_ports ( ing_16b_phys_ports ),
        .rst                ( rst                ),
        .pkt_avail          ( pkt_avail          ),
        .rd_data            ( rd_data            ),
        .rd_keep            ( rd_keep            ),
        .rd_last            ( rd_last            ),
        .rd_pop             ( rd_pop             ),
        .out_valid          ( out_valid          ),
        .out_data           ( out_data           ),
        .out_keep           ( out_keep           ),
        .out_last           ( out_last           ),
        .out_user           ( out_user           ),
        .out_ready          ( out_ready          ),
        .pkt_sent           ( pkt_sent           )
    );

    ingress_sat_counter #(
        .WIDTH ( CW )
    ) u_bus_cnt (
        .ing_16b_phys_ports ( ing_16b_phys_ports ),
        .rst                ( rst                ),
        .clear              ( bus_pkt_cnt_clear  ),
        .inc                ( pkt_sent           ),
        .count              ( bus_pkt_cnt        )
    );

endmodule

`default_nettype wire

//--- ingress_buffer/ingress_scheduler.sv
////////////////////////////////////////////////////////////////////////////
// Round-robin packet scheduler and wide output multiplexer
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ingress_scheduler #(
    parameter int NUM_PORTS = 4,
    localparam int UW       = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1,
    localparam int OUT_B    = ingress_pkg::OUT_DATA_BYTES
) (
    input  var logic                         ing_16b_phys_ports,
    input  var logic                         rst,
    input  var logic [NUM_PORTS-1:0]         pkt_avail,
    input  var logic [NUM_PORTS*OUT_B*8-1:0] rd_data,
    input  var logic [NUM_PORTS*OUT_B-1:0]   rd_keep,
    input  var logic [NUM_PORTS-1:0]         rd_last,
    output logic [NUM_PORTS-1:0]             rd_pop,
    output logic                             out_valid,
    output logic [OUT_B*8-1:0]               out_data,
    output logic [OUT_B-1:0]                 out_keep,
    output logic                             out_last,
    output logic [UW-1:0]                    out_user,
    input  var logic                         out_ready,
    output logic                             pkt_sent
);

    ingress_pkg::sched_state_t state;

    logic [UW-1:0] grant;
    logic [UW-1:0] last_grant;
    logic [UW-1:0] next_port;
    logic          found;
    logic          xfer;

    // Search starts one past the port served last
    always_comb begin : rr_search
        int idx;
        found     = 1'b0;
        next_port = last_grant;
        for (int i = 1; i <= NUM_PORTS; i++) begin
            idx = (int'(last_grant) + i) % NUM_PORTS;
            if (!found && pkt_avail[idx]) begin
                found     = 1'b1;
                next_port = UW'(idx);
            end
        end
    end

    assign out_valid = (state == ingress_pkg::SCHED_SEND);
    assign out_data  = rd_data[grant*OUT_B*8 +: OUT_B*8];
    assign out_keep  = rd_keep[grant*OUT_B +: OUT_B];
    assign out_last  = rd_last[grant];
    assign out_user  = grant;
    assign xfer      = out_valid && out_ready;
    assign pkt_sent  = xfer && out_last;

    always_comb begin
        rd_pop        = '0;
        rd_pop[grant] = xfer;
    end

    always_ff @(posedge ing_16b_phys_ports) begin
        if (rst) begin
            state      <= ingress_pkg::SCHED_IDLE;
            grant      <= '0;
            last_grant <= UW'(NUM_PORTS - 1);
        end else begin
            case (state)
                ingress_pkg::SCHED_IDLE: begin
                    if (found) begin
                        grant <= next_port;
                        state <= ingress_pkg::SCHED_SEND;
                    end
                end
                ingress_pkg::SCHED_SEND: begin
                    if (pkt_sent) begin
                        last_grant <= grant;
                        state      <= ingress_pkg::SCHED_IDLE;
                    end
                end
                default: state <= ingress_pkg::SCHED_IDLE;
            endcase
        end
    end

    // A stalled word must hold until it is taken
    a_out_stable : assert property (@(posedge ing_16b_phys_ports) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_keep)
            && $stable(out_last) && $stable(out_user));

endmodule

`default_nettype wire

//--- ingress_buffer/ingress_port_buffer.sv
////////////////////////////////////////////////////////////////////////////
// Per-port store-and-forward packet buffer, drops whole packets on overflow
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ingress_port_buffer #(
    parameter int BUF_DEPTH = 16
) (
    input  var logic                                      ing_16b_phys_ports,
    input  var logic                                      rst,
    input  var logic                                      cnt_clear,
    input  var logic                                      wr_valid,
    input  var logic [ingress_pkg::OUT_DATA_BYTES*8-1:0]  wr_data,
    input  var logic [ingress_pkg::OUT_DATA_BYTES-1:0]    wr_keep,
    input  var logic                                      wr_last,
    input  var logic                                      rd_pop,
    output logic                                          pkt_avail,
    output logic [ingress_pkg::OUT_DATA_BYTES*8-1:0]      rd_data,
    output logic [ingress_pkg::OUT_DATA_BYTES-1:0]        rd_keep,
    output logic                                          rd_last,
    output logic                                          pkt_commit,
    output logic                                          pkt_drop,
    output logic                                          overflow
);

    localparam int AW = $clog2(BUF_DEPTH);
    localparam int DW = ingress_pkg::OUT_DATA_BYTES * 9 + 1;

    logic [DW-1:0] mem [BUF_DEPTH];

    // Pointers carry one extra bit so a full buffer differs from an empty one
    logic [AW:0] wr_spec;
    logic [AW:0] wr_commit;
    logic [AW:0] rd_ptr;
    logic [AW:0] pkt_cnt;
    logic        dropping;
    logic        full;
    logic        wr_take;
    logic        commit_now;
    logic        drop_now;
    logic        pop_last;

    assign full       = (wr_spec - rd_ptr) == (AW+1)'(BUF_DEPTH);
    assign wr_take    = wr_valid && !dropping && !full;
    assign commit_now = wr_take && wr_last;
    assign drop_now   = wr_valid && !dropping && full;
    assign pop_last   = rd_pop && rd_last;
    assign pkt_avail  = (pkt_cnt != '0);

    always_ff @(posedge ing_16b_phys_ports) begin
        if (wr_take) begin
            mem[wr_spec[AW-1:0]] <= {wr_last, wr_keep, wr_data};
        end
    end

    // Head word is visible with no read latency
    assign {rd_last, rd_keep, rd_data} = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge ing_16b_phys_ports) begin
        if (rst) begin
            wr_spec    <= '0;
            wr_commit  <= '0;
            rd_ptr     <= '0;
            pkt_cnt    <= '0;
            dropping   <= 1'b0;
            pkt_commit <= 1'b0;
            pkt_drop   <= 1'b0;
            overflow   <= 1'b0;
        end else begin
            pkt_commit <= commit_now;
            pkt_drop   <= drop_now;
            pkt_cnt    <= pkt_cnt + (AW+1)'(commit_now) - (AW+1)'(pop_last);
            if (rd_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (wr_take) begin
                wr_spec <= wr_spec + 1'b1;
                if (wr_last) begin
                    wr_commit <= wr_spec + 1'b1;
                end
            end
            // Rewind to the last committed packet and skip the rest of this one
            if (drop_now) begin
                wr_spec  <= wr_commit;
                dropping <= !wr_last;
            end else if (dropping && wr_valid && wr_last) begin
                dropping <= 1'b0;
            end
            if (cnt_clear) begin
                overflow <= 1'b0;
            end else if (drop_now) begin
                overflow <= 1'b1;
            end
        end
    end

    // The scheduler may only pop a port that holds a complete packet
    a_pop_avail : assert property (@(posedge ing_16b_phys_ports) disable iff (rst)
        rd_pop |-> pkt_avail);

endmodule

`default_nettype wire

//--- hw/ingress_width_adapt.sv
////////////////////////////////////////////////////////////////////////////
// Packs 16-bit beats of one ingress port into 64-bit words with byte keep
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ingress_width_adapt (
    input  var logic                                      ing_16b_phys_ports,
    input  var logic                                      rst,
    input  var logic                                      enable,
    input  var logic                                      in_valid,
    input  var logic [ingress_pkg::IN_DATA_BYTES*8-1:0]   in_data,
    input  var logic [ingress_pkg::IN_DATA_BYTES-1:0]     in_keep,
    input  var logic                                      in_last,
    output logic                                          wr_valid,
    output logic [ingress_pkg::OUT_DATA_BYTES*8-1:0]      wr_data,
    output logic [ingress_pkg::OUT_DATA_BYTES-1:0]        wr_keep,
    output logic                                          wr_last
);

    localparam int IN_BYTES = ingress_pkg::IN_DATA_BYTES;
    localparam int IN_W     = IN_BYTES * 8;
    localparam int BW       = $clog2(ingress_pkg::BEATS_PER_WORD);

    logic [BW-1:0]                             beat_idx;
    logic [ingress_pkg::OUT_DATA_BYTES*8-1:0]  next_data;
    logic [ingress_pkg::OUT_DATA_BYTES-1:0]    next_keep;
    logic                                      take;
    logic                                      word_done;

    assign take      = in_valid && enable;
    assign word_done = in_last || (beat_idx == BW'(ingress_pkg::BEATS_PER_WORD - 1));

    // The first beat of a word starts from zero so unused bytes never carry stale data
    always_comb begin
        next_data = (beat_idx == '0) ? '0 : wr_data;
        next_keep = (beat_idx == '0) ? '0 : wr_keep;
        next_data[beat_idx*IN_W +: IN_W] = in_data;
        next_keep[beat_idx*IN_BYTES +: IN_BYTES] = in_keep;
    end

    // A low enable throws away any partly gathered word
    always_ff @(posedge ing_16b_phys_ports) begin
        if (rst || !enable) begin
            beat_idx <= '0;
            wr_valid <= 1'b0;
        end else begin
            wr_valid <= take && word_done;
            if (take) begin
                beat_idx <= word_done ? '0 : beat_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge ing_16b_phys_ports) begin
        if (take) begin
            wr_data <= next_data;
            wr_keep <= next_keep;
            wr_last <= in_last;
        end
    end

    // Only the last beat of a packet may be partial
    a_full_keep : assert property (@(posedge ing_16b_phys_ports) disable iff (rst)
        take && !in_last |-> in_keep == '1);

endmodule

`default_nettype wire

//--- hw/ingress_sat_counter.sv
////////////////////////////////////////////////////////////////////////////
// Saturating event counter with synchronous clear
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ingress_sat_counter #(
    parameter int WIDTH = 32
) (
    input  var logic        ing_16b_phys_ports,
    input  var logic        rst,
    input  var logic        clear,
    input  var logic        inc,
    output logic [WIDTH-1:0] count
);

    // Clear wins over a same-cycle event, and the count sticks at all ones
    always_ff @(posedge ing_16b_phys_ports) begin
        if (rst || clear) begin
            count <= '0;
        end else if (inc && !(&count)) begin
            count <= count + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- common/ingress_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Ingress aggregator shared widths, buffer depth rule and scheduler state
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package ingress_pkg;

    // Bytes per narrow input beat and per wide output word
    localparam int IN_DATA_BYTES  = 2;
    localparam int OUT_DATA_BYTES = 8;
    localparam int BEATS_PER_WORD = 4;

    localparam int CNT_WIDTH = 32;

    // Output words that hold one MTU, a partial word counts as a whole one
    function automatic int mtu_words(input int mtu_bytes);
        return (mtu_bytes + OUT_DATA_BYTES - 1) / OUT_DATA_BYTES;
    endfunction

    // Twice the MTU so near power-of-two MTUs still fit, rounded up to a power of two
    function automatic int buf_depth_for_mtu(input int mtu_bytes);
        int depth;
        depth = 1;
        while (depth < 2 * mtu_words(mtu_bytes)) begin
            depth = depth * 2;
        end
        return depth;
    endfunction

    typedef enum logic {
        SCHED_IDLE = 1'b0,
        SCHED_SEND = 1'b1
    } sched_state_t;

endpackage

`default_nettype wire
